//--- hdl/tcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tcache (
    input  logic                        clk,
    input  logic                        reset,
    input  tlb_types_pkg::vppn_t        vppn,
    input  logic                        va_bit12,
    input  tlb_types_pkg::asid_t        asid,
    input  logic                        flush,
    input  tlb_ctrl_pkg::tlb_refill_t   refill,
    output tlb_types_pkg::tlb_result_t  result
);

    localparam int PTR_W = (`TCACHE_ENTRIES > 1) ? $clog2(`TCACHE_ENTRIES) : 1;

    tlb_types_pkg::tlb_entry_t slot_entry [`TCACHE_ENTRIES];
    tlb_types_pkg::tlb_idx_t slot_index [`TCACHE_ENTRIES];
    logic [`TCACHE_ENTRIES-1:0] slot_valid;
    logic [PTR_W-1:0] rr_ptr;

    logic hit;
    logic [PTR_W-1:0] hit_slot;

    always_comb begin
        hit = 1'b0;
        hit_slot = '0;
        for (int i = `TCACHE_ENTRIES - 1; i >= 0; i--) begin
            if (slot_valid[i] && tlb_types_pkg::entry_match(slot_entry[i], vppn, asid)) begin
                hit = 1'b1;
                hit_slot = PTR_W'(i);
            end
        end
    end

    assign result = tlb_types_pkg::select_page(slot_entry[hit_slot], va_bit12, vppn[8],
                                               hit, slot_index[hit_slot]);

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= '0;
            rr_ptr <= '0;
        end else if (flush) begin
            // write or invtlb may have changed any cached entry
            slot_valid <= '0;
        end else if (refill.valid) begin
            slot_valid[rr_ptr] <= 1'b1;
            rr_ptr <= (rr_ptr == PTR_W'(`TCACHE_ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
        end
    end

    // payload only, qualified by slot_valid
    always_ff @(posedge clk) begin
        if (refill.valid) begin
            slot_entry[rr_ptr] <= refill.entry;
            slot_index[rr_ptr] <= refill.index;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tlb_ctrl_pkg.sv
`default_nettype none

`include "tlb_cfg.svh"

package tlb_ctrl_pkg;

    typedef enum logic [1:0] {
        PORT_CACHE,
        PORT_L2_LOOKUP,
        PORT_L2_FETCH,
        PORT_REFILL
    } port_state_e;

    // invtlb op field as in the ISA
    typedef enum logic [4:0] {
        INV_ALL_0     = 5'd0,
        INV_ALL_1     = 5'd1,
        INV_G         = 5'd2,
        INV_NG        = 5'd3,
        INV_ASID      = 5'd4,
        INV_ASID_VA   = 5'd5,
        INV_G_ASID_VA = 5'd6
    } invtlb_op_e;

    typedef struct packed {
        logic                 valid;
        invtlb_op_e           op;
        tlb_types_pkg::asid_t asid;
        logic [31:0]          va;
    } invtlb_req_t;

    typedef struct packed {
        logic                      we;
        logic [`TLB_IDX_W-1:0]     index;
        tlb_types_pkg::tlb_entry_t entry;
    } tlb_write_t;

    typedef struct packed {
        logic                      valid;
        tlb_types_pkg::tlb_idx_t   index;
        tlb_types_pkg::tlb_entry_t entry;
    } tlb_refill_t;

endpackage

`default_nettype wire

//--- hdl/tlb_main.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_main (
    input  logic                       clk,
    input  logic                       reset,

    input  tlb_types_pkg::vppn_t       s0_vppn,
    input  tlb_types_pkg::asid_t       s0_asid,
    output logic                       s0_found,
    output tlb_types_pkg::tlb_idx_t    s0_index,
    output tlb_types_pkg::tlb_entry_t  s0_entry,

    input  tlb_types_pkg::vppn_t       s1_vppn,
    input  tlb_types_pkg::asid_t       s1_asid,
    output logic                       s1_found,
    output tlb_types_pkg::tlb_idx_t    s1_index,
    output tlb_types_pkg::tlb_entry_t  s1_entry,

    input  tlb_ctrl_pkg::invtlb_req_t  invtlb,
    input  tlb_ctrl_pkg::tlb_write_t   wr,
    input  tlb_types_pkg::tlb_idx_t    r_index,
    output tlb_types_pkg::tlb_entry_t  r_entry
);

    tlb_types_pkg::tlb_entry_t entries [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] inv_mask;

    // lowest matching index wins
    always_comb begin
        s0_found = 1'b0;
        s0_index = '0;
        s1_found = 1'b0;
        s1_index = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (tlb_types_pkg::entry_match(entries[i], s0_vppn, s0_asid)) begin
                s0_found = 1'b1;
                s0_index = tlb_types_pkg::tlb_idx_t'(i);
            end
            if (tlb_types_pkg::entry_match(entries[i], s1_vppn, s1_asid)) begin
                s1_found = 1'b1;
                s1_index = tlb_types_pkg::tlb_idx_t'(i);
            end
        end
    end

    assign s0_entry = entries[s0_index];
    assign s1_entry = entries[s1_index];
    assign r_entry = entries[r_index];

    // entries to drop for the current invtlb op
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            case (invtlb.op)
                tlb_ctrl_pkg::INV_ALL_0,
                tlb_ctrl_pkg::INV_ALL_1: inv_mask[i] = 1'b1;
                tlb_ctrl_pkg::INV_G:     inv_mask[i] = entries[i].g;
                tlb_ctrl_pkg::INV_NG:    inv_mask[i] = !entries[i].g;
                tlb_ctrl_pkg::INV_ASID:
                    inv_mask[i] = !entries[i].g && entries[i].asid == invtlb.asid;
                tlb_ctrl_pkg::INV_ASID_VA:
                    inv_mask[i] = !entries[i].g && entries[i].asid == invtlb.asid
                                  && tlb_types_pkg::vppn_match(entries[i], invtlb.va[31:13]);
                tlb_ctrl_pkg::INV_G_ASID_VA:
                    inv_mask[i] = (entries[i].g || entries[i].asid == invtlb.asid)
                                  && tlb_types_pkg::vppn_match(entries[i], invtlb.va[31:13]);
                default: inv_mask[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i].e <= 1'b0;
            end
        end else begin
            if (invtlb.valid) begin
                for (int i = 0; i < `TLB_ENTRIES; i++) begin
                    if (inv_mask[i]) begin
                        entries[i].e <= 1'b0;
                    end
                end
            end
            // a write in the same cycle wins over the invalidate
            if (wr.we) begin
                entries[wr.index] <= wr.entry;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/tlb_port_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_port_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  tlb_types_pkg::vppn_t        vppn,
    input  logic                        va_bit12,
    input  tlb_types_pkg::asid_t        asid,
    input  logic                        valid,
    input  tlb_types_pkg::tlb_result_t  tc_result,
    input  logic                        l2_found,
    input  tlb_types_pkg::tlb_idx_t     l2_index,
    input  tlb_types_pkg::tlb_entry_t   l2_entry,
    output tlb_types_pkg::vppn_t        l2_vppn,
    output tlb_types_pkg::asid_t        l2_asid,
    output tlb_types_pkg::tlb_result_t  result,
    output logic                        ok,
    output tlb_ctrl_pkg::tlb_refill_t   refill
);

    tlb_ctrl_pkg::port_state_e state;

    // lookup registers, frozen while the main TLB is busy
    tlb_types_pkg::vppn_t vppn_q;
    tlb_types_pkg::asid_t asid_q;
    logic va_bit12_q;

    logic buf_valid;
    tlb_types_pkg::tlb_idx_t buf_index;
    tlb_types_pkg::tlb_entry_t buf_entry;

    tlb_types_pkg::tlb_result_t l2_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= tlb_ctrl_pkg::PORT_CACHE;
        end else begin
            case (state)
                tlb_ctrl_pkg::PORT_CACHE: begin
                    if (valid && !tc_result.found) begin
                        state <= tlb_ctrl_pkg::PORT_L2_LOOKUP;
                    end
                end
                tlb_ctrl_pkg::PORT_L2_LOOKUP: begin
                    state <= valid ? tlb_ctrl_pkg::PORT_L2_FETCH : tlb_ctrl_pkg::PORT_CACHE;
                end
                tlb_ctrl_pkg::PORT_L2_FETCH: begin
                    state <= valid ? tlb_ctrl_pkg::PORT_REFILL : tlb_ctrl_pkg::PORT_CACHE;
                end
                default: begin
                    state <= tlb_ctrl_pkg::PORT_CACHE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == tlb_ctrl_pkg::PORT_CACHE) begin
            vppn_q <= vppn;
            asid_q <= asid;
            va_bit12_q <= va_bit12;
        end
    end

    // refill buffer loaded at the end of the fetch cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else begin
            buf_valid <= state == tlb_ctrl_pkg::PORT_L2_FETCH && valid && l2_found;
        end
    end

    always_ff @(posedge clk) begin
        if (state == tlb_ctrl_pkg::PORT_L2_FETCH) begin
            buf_index <= l2_index;
            buf_entry <= l2_entry;
        end
    end

    assign l2_vppn = vppn_q;
    assign l2_asid = asid_q;

    assign l2_result = tlb_types_pkg::select_page(l2_entry, va_bit12_q, vppn_q[8],
                                                  l2_found, l2_index);

    assign result = (state == tlb_ctrl_pkg::PORT_CACHE) ? tc_result : l2_result;
    assign ok = (state == tlb_ctrl_pkg::PORT_CACHE && valid && tc_result.found)
                || state == tlb_ctrl_pkg::PORT_REFILL;

    assign refill.valid = buf_valid && state == tlb_ctrl_pkg::PORT_REFILL;
    assign refill.index = buf_index;
    assign refill.entry = buf_entry;

endmodule

`default_nettype wire

//--- hdl/tlb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_top (
    input  logic                        clk,
    input  logic                        reset,

    // fetch port
    input  tlb_types_pkg::vppn_t        s0_vppn,
    input  logic                        s0_va_bit12,
    input  tlb_types_pkg::asid_t        s0_asid,
    input  logic                        s0_valid,
    output tlb_types_pkg::tlb_result_t  s0_result,
    output logic                        s0_ok,

    // load/store port
    input  tlb_types_pkg::vppn_t        s1_vppn,
    input  logic                        s1_va_bit12,
    input  tlb_types_pkg::asid_t        s1_asid,
    input  logic                        s1_valid,
    output tlb_types_pkg::tlb_result_t  s1_result,
    output logic                        s1_ok,

    input  tlb_ctrl_pkg::invtlb_req_t   invtlb,
    input  tlb_ctrl_pkg::tlb_write_t    wr,
    input  tlb_types_pkg::tlb_idx_t     r_index,
    output tlb_types_pkg::tlb_entry_t   r_entry
);

    // any change to the main TLB drops both tcaches
    logic flush;

    tlb_types_pkg::tlb_result_t tc0_result;
    tlb_types_pkg::tlb_result_t tc1_result;
    tlb_ctrl_pkg::tlb_refill_t refill0;
    tlb_ctrl_pkg::tlb_refill_t refill1;

    tlb_types_pkg::vppn_t l2_vppn0;
    tlb_types_pkg::vppn_t l2_vppn1;
    tlb_types_pkg::asid_t l2_asid0;
    tlb_types_pkg::asid_t l2_asid1;
    logic l2_found0;
    logic l2_found1;
    tlb_types_pkg::tlb_idx_t l2_index0;
    tlb_types_pkg::tlb_idx_t l2_index1;
    tlb_types_pkg::tlb_entry_t l2_entry0;
    tlb_types_pkg::tlb_entry_t l2_entry1;

    assign flush = wr.we || invtlb.valid;

    tcache u_tcache_inst (
        .clk      (clk),
        .reset    (reset),
        .vppn     (s0_vppn),
        .va_bit12 (s0_va_bit12),
        .asid     (s0_asid),
        .flush    (flush),
        .refill   (refill0),
        .result   (tc0_result)
    );

    tcache u_tcache_data (
        .clk      (clk),
        .reset    (reset),
        .vppn     (s1_vppn),
        .va_bit12 (s1_va_bit12),
        .asid     (s1_asid),
        .flush    (flush),
        .refill   (refill1),
        .result   (tc1_result)
    );

    tlb_port_ctrl u_ctrl_inst (
        .clk       (clk),
        .reset     (reset),
        .vppn      (s0_vppn),
        .va_bit12  (s0_va_bit12),
        .asid      (s0_asid),
        .valid     (s0_valid),
        .tc_result (tc0_result),
        .l2_found  (l2_found0),
        .l2_index  (l2_index0),
        .l2_entry  (l2_entry0),
        .l2_vppn   (l2_vppn0),
        .l2_asid   (l2_asid0),
        .result    (s0_result),
        .ok        (s0_ok),
        .refill    (refill0)
    );

    tlb_port_ctrl u_ctrl_data (
        .clk       (clk),
        .reset     (reset),
        .vppn      (s1_vppn),
        .va_bit12  (s1_va_bit12),
        .asid      (s1_asid),
        .valid     (s1_valid),
        .tc_result (tc1_result),
        .l2_found  (l2_found1),
        .l2_index  (l2_index1),
        .l2_entry  (l2_entry1),
        .l2_vppn   (l2_vppn1),
        .l2_asid   (l2_asid1),
        .result    (s1_result),
        .ok        (s1_ok),
        .refill    (refill1)
    );

    tlb_main u_main (
        .clk      (clk),
        .reset    (reset),
        .s0_vppn  (l2_vppn0),
        .s0_asid  (l2_asid0),
        .s0_found (l2_found0),
        .s0_index (l2_index0),
        .s0_entry (l2_entry0),
        .s1_vppn  (l2_vppn1),
        .s1_asid  (l2_asid1),
        .s1_found (l2_found1),
        .s1_index (l2_index1),
        .s1_entry (l2_entry1),
        .invtlb   (invtlb),
        .wr       (wr),
        .r_index  (r_index),
        .r_entry  (r_entry)
    );

endmodule

`default_nettype wire

//--- hdl/tlb_types_pkg.sv
`default_nettype none

`include "tlb_cfg.svh"

package tlb_types_pkg;

    typedef logic [18:0] vppn_t;
    typedef logic [9:0] asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0] ps_t;
    typedef logic [1:0] plv_t;
    typedef logic [1:0] mat_t;
    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;

    // one entry maps an even/odd page pair
    typedef struct packed {
        vppn_t vppn;
        ps_t   ps;
        logic  g;
        asid_t asid;
        logic  e;
        ppn_t  ppn0;
        plv_t  plv0;
        mat_t  mat0;
        logic  d0;
        logic  v0;
        ppn_t  ppn1;
        plv_t  plv1;
        mat_t  mat1;
        logic  d1;
        logic  v1;
    } tlb_entry_t;

    typedef struct packed {
        logic     found;
        tlb_idx_t index;
        ppn_t     ppn;
        ps_t      ps;
        plv_t     plv;
        mat_t     mat;
        logic     d;
        logic     v;
    } tlb_result_t;

    // 2M pages ignore the low 9 vppn bits
    function automatic logic vppn_match(tlb_entry_t ent, vppn_t vppn);
        if (ent.ps == `PS_2M) begin
            return ent.vppn[18:9] == vppn[18:9];
        end
        return ent.vppn == vppn;
    endfunction

    function automatic logic entry_match(tlb_entry_t ent, vppn_t vppn, asid_t asid);
        return ent.e && (ent.g || ent.asid == asid) && vppn_match(ent, vppn);
    endfunction

    // pick the even or odd half of a matched pair
    function automatic tlb_result_t select_page(tlb_entry_t ent, logic va_bit12,
                                                logic vppn_bit8, logic found,
                                                tlb_idx_t index);
        tlb_result_t res;
        logic even;
        even = (ent.ps == `PS_4K && !va_bit12) || (ent.ps == `PS_2M && !vppn_bit8);
        res.found = found;
        res.index = index;
        res.ps = ent.ps;
        res.ppn = even ? ent.ppn0 : ent.ppn1;
        res.plv = even ? ent.plv0 : ent.plv1;
        res.mat = even ? ent.mat0 : ent.mat1;
        res.d = even ? ent.d0 : ent.d1;
        res.v = even ? ent.v0 : ent.v1;
        return res;
    endfunction

endpackage

`default_nettype wire

//--- include/tlb_cfg.svh
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// main TLB geometry
`define TLB_ENTRIES 16
`define TLB_IDX_W 4

// per-port translation cache
`define TCACHE_ENTRIES 2

// page size codes
`define PS_4K 12
`define PS_2M 21

`endif

//--- testbench/tlb_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_port_chk (
    input logic                        clk,
    input logic                        reset,
    input tlb_ctrl_pkg::port_state_e   state,
    input logic                        ok,
    input logic                        refill_valid
);

    int fails = 0;

    // ok only in the two answering states
    a_ok_state: assert property (@(posedge clk) disable iff (reset)
        ok |-> (state == tlb_ctrl_pkg::PORT_CACHE || state == tlb_ctrl_pkg::PORT_REFILL))
        else begin
            fails++;
            $error("ok raised in port state %0d", state);
        end

    a_refill_once: assert property (@(posedge clk) disable iff (reset)
        state == tlb_ctrl_pkg::PORT_REFILL |=> state != tlb_ctrl_pkg::PORT_REFILL)
        else begin
            fails++;
            $error("port stayed in PORT_REFILL for more than one cycle");
        end

    a_refill_state: assert property (@(posedge clk) disable iff (reset)
        refill_valid |-> state == tlb_ctrl_pkg::PORT_REFILL)
        else begin
            fails++;
            $error("tcache refill issued outside PORT_REFILL");
        end

    // lookup either proceeds or is aborted
    a_lookup_next: assert property (@(posedge clk) disable iff (reset)
        state == tlb_ctrl_pkg::PORT_L2_LOOKUP |=>
            (state == tlb_ctrl_pkg::PORT_L2_FETCH || state == tlb_ctrl_pkg::PORT_CACHE))
        else begin
            fails++;
            $error("illegal state after PORT_L2_LOOKUP");
        end

endmodule

bind tlb_port_ctrl tlb_port_chk u_port_chk (
    .clk          (clk),
    .reset        (reset),
    .state        (state),
    .ok           (ok),
    .refill_valid (refill.valid)
);

`default_nettype wire

//--- testbench/tlb_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_top_tb;

    localparam int K_WR = 0;
    localparam int K_RD = 1;
    localparam int K_S0 = 2;
    localparam int K_S1 = 3;
    localparam int K_BOTH = 4;
    localparam int K_INV = 5;
    localparam int K_ABORT = 6;

    // hit bit 0 is the fetch port, bit 1 the load/store port
    typedef struct packed {
        logic [2:0]              kind;
        tlb_types_pkg::tlb_idx_t idx;
        tlb_types_pkg::vppn_t    vppn;
        tlb_types_pkg::vppn_t    vppn_b;
        logic                    va12;
        tlb_types_pkg::asid_t    asid;
        logic                    g;
        logic                    big;
        logic [4:0]              op;
        logic [1:0]              hit;
        tlb_types_pkg::ppn_t     ppn0;
        tlb_types_pkg::ppn_t     ppn1;
        logic [11:0]             pbits;
    } row_t;

    logic clk = 1'b0;
    logic reset;
    tlb_types_pkg::vppn_t s0_vppn;
    logic s0_va_bit12;
    tlb_types_pkg::asid_t s0_asid;
    logic s0_valid;
    tlb_types_pkg::tlb_result_t s0_result;
    logic s0_ok;
    tlb_types_pkg::vppn_t s1_vppn;
    logic s1_va_bit12;
    tlb_types_pkg::asid_t s1_asid;
    logic s1_valid;
    tlb_types_pkg::tlb_result_t s1_result;
    logic s1_ok;
    tlb_ctrl_pkg::invtlb_req_t invtlb;
    tlb_ctrl_pkg::tlb_write_t wr;
    tlb_types_pkg::tlb_idx_t r_index;
    tlb_types_pkg::tlb_entry_t r_entry;

    // reference model state
    tlb_types_pkg::tlb_entry_t shadow [`TLB_ENTRIES];
    tlb_types_pkg::tlb_idx_t tc_idx [2][`TCACHE_ENTRIES];
    logic tc_v [2][`TCACHE_ENTRIES];
    int tc_ptr [2];

    row_t rows [$];
    int errors = 0;
    int cycles = 0;
    int limit = 1000;

    tlb_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .s0_vppn     (s0_vppn),
        .s0_va_bit12 (s0_va_bit12),
        .s0_asid     (s0_asid),
        .s0_valid    (s0_valid),
        .s0_result   (s0_result),
        .s0_ok       (s0_ok),
        .s1_vppn     (s1_vppn),
        .s1_va_bit12 (s1_va_bit12),
        .s1_asid     (s1_asid),
        .s1_valid    (s1_valid),
        .s1_result   (s1_result),
        .s1_ok       (s1_ok),
        .invtlb      (invtlb),
        .wr          (wr),
        .r_index     (r_index),
        .r_entry     (r_entry)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            errors++;
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("checks done, %0d errors", errors);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic page_hit(tlb_types_pkg::tlb_entry_t ent, tlb_types_pkg::vppn_t vppn);
        if (ent.ps == `PS_2M) begin
            return ent.vppn[18:9] == vppn[18:9];
        end
        return ent.vppn == vppn;
    endfunction

    function automatic logic entry_hits(tlb_types_pkg::tlb_entry_t ent,
                                        tlb_types_pkg::vppn_t vppn, tlb_types_pkg::asid_t asid);
        return ent.e && (ent.g || ent.asid == asid) && page_hit(ent, vppn);
    endfunction

    // lowest matching index answers
    function automatic tlb_types_pkg::tlb_result_t expected_result(tlb_types_pkg::vppn_t vppn,
                                                                   logic va12,
                                                                   tlb_types_pkg::asid_t asid);
        tlb_types_pkg::tlb_result_t r;
        tlb_types_pkg::tlb_entry_t ent;
        logic odd;
        r = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!r.found && entry_hits(shadow[i], vppn, asid)) begin
                ent = shadow[i];
                odd = (ent.ps == `PS_4K) ? va12 : vppn[8];
                r.found = 1'b1;
                r.index = tlb_types_pkg::tlb_idx_t'(i);
                r.ps = ent.ps;
                r.ppn = odd ? ent.ppn1 : ent.ppn0;
                {r.plv, r.mat, r.d, r.v} = odd ? {ent.plv1, ent.mat1, ent.d1, ent.v1}
                                               : {ent.plv0, ent.mat0, ent.d0, ent.v0};
            end
        end
        return r;
    endfunction

    function automatic logic cached_in_port(int p, tlb_types_pkg::vppn_t vppn,
                                            tlb_types_pkg::asid_t asid);
        for (int s = 0; s < `TCACHE_ENTRIES; s++) begin
            if (tc_v[p][s] && entry_hits(shadow[tc_idx[p][s]], vppn, asid)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic flush_model();
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < `TCACHE_ENTRIES; s++) begin
                tc_v[p][s] = 1'b0;
            end
        end
    endtask

    task automatic add(input int kind, idx, vppn, vppn_b, va12, asid, g, big, op, hit);
        row_t r;
        r.kind = 3'(kind);
        r.idx = tlb_types_pkg::tlb_idx_t'(idx);
        r.vppn = tlb_types_pkg::vppn_t'(vppn);
        r.vppn_b = tlb_types_pkg::vppn_t'(vppn_b);
        r.va12 = 1'(va12);
        r.asid = tlb_types_pkg::asid_t'(asid);
        r.g = 1'(g);
        r.big = 1'(big);
        r.op = 5'(op);
        r.hit = 2'(hit);
        r.ppn0 = tlb_types_pkg::ppn_t'($urandom);
        r.ppn1 = tlb_types_pkg::ppn_t'($urandom);
        r.pbits = 12'($urandom);
        rows.push_back(r);
    endtask

    task automatic write_entry(input row_t r);
        tlb_types_pkg::tlb_entry_t ent;
        ent.vppn = r.vppn;
        ent.ps = r.big ? tlb_types_pkg::ps_t'(`PS_2M) : tlb_types_pkg::ps_t'(`PS_4K);
        ent.g = r.g;
        ent.asid = r.asid;
        ent.e = 1'b1;
        ent.ppn0 = r.ppn0;
        ent.ppn1 = r.ppn1;
        {ent.plv0, ent.mat0, ent.d0, ent.v0, ent.plv1, ent.mat1, ent.d1, ent.v1} = r.pbits;
        @(posedge clk);
        wr <= '{we: 1'b1, index: r.idx, entry: ent};
        @(posedge clk);
        wr.we <= 1'b0;
        shadow[r.idx] = ent;
        flush_model();
    endtask

    task automatic read_back(input row_t r);
        @(posedge clk);
        r_index <= r.idx;
        @(negedge clk);
        assert (r_entry === shadow[r.idx]) else begin
            errors++;
            $display("CHECK FAILED at %0t: entry %0d read back as %h, expected %h",
                     $time, r.idx, r_entry, shadow[r.idx]);
        end
    endtask

    task automatic invalidate(input row_t r);
        logic kill;
        @(posedge clk);
        invtlb.valid <= 1'b1;
        invtlb.op <= tlb_ctrl_pkg::invtlb_op_e'(r.op);
        invtlb.asid <= r.asid;
        invtlb.va <= {r.vppn, 13'h0};
        @(posedge clk);
        invtlb.valid <= 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            case (r.op)
                5'd0, 5'd1: kill = 1'b1;
                5'd2: kill = shadow[i].g;
                5'd3: kill = !shadow[i].g;
                5'd4: kill = !shadow[i].g && shadow[i].asid == r.asid;
                5'd5: kill = !shadow[i].g && shadow[i].asid == r.asid
                             && page_hit(shadow[i], r.vppn);
                default: kill = (shadow[i].g || shadow[i].asid == r.asid)
                                && page_hit(shadow[i], r.vppn);
            endcase
            if (kill) begin
                shadow[i].e = 1'b0;
            end
        end
        flush_model();
    endtask

    task automatic check_answer(input int p, input int lat, input int exp_lat,
                                input tlb_types_pkg::tlb_result_t exp);
        tlb_types_pkg::tlb_result_t got;
        got = p ? s1_result : s0_result;
        assert (lat == exp_lat) else begin
            errors++;
            $display("CHECK FAILED at %0t: port %0d answered after %0d cycles, expected %0d",
                     $time, p, lat, exp_lat);
        end
        assert (exp.found ? got === exp : (got.found === 1'b0 && got.index === '0)) else begin
            errors++;
            $display("CHECK FAILED at %0t: port %0d result %h, expected %h",
                     $time, p, got, exp);
        end
    endtask

    task automatic search_ports(input row_t r, input logic [1:0] use_p);
        tlb_types_pkg::vppn_t q [2];
        tlb_types_pkg::tlb_result_t exp_r [2];
        int exp_lat [2];
        logic [1:0] pending;
        logic [1:0] seen;
        int waited;
        q[0] = r.vppn;
        q[1] = (r.kind == K_BOTH) ? r.vppn_b : r.vppn;
        for (int p = 0; p < 2; p++) begin
            exp_r[p] = expected_result(q[p], r.va12, r.asid);
            exp_lat[p] = cached_in_port(p, q[p], r.asid) ? 0 : 3;
            assert (!use_p[p] || r.hit[p] == (exp_lat[p] == 0)) else begin
                errors++;
                $display("stimulus table and model disagree on the path of port %0d", p);
            end
        end
        @(posedge clk);
        s0_valid <= use_p[0];
        s0_vppn <= q[0];
        s0_va_bit12 <= r.va12;
        s0_asid <= r.asid;
        s1_valid <= use_p[1];
        s1_vppn <= q[1];
        s1_va_bit12 <= r.va12;
        s1_asid <= r.asid;
        pending = use_p;
        waited = 0;
        while (pending != 2'b00 && waited < 6) begin
            @(negedge clk);
            seen = pending & {s1_ok, s0_ok};
            for (int p = 0; p < 2; p++) begin
                if (seen[p]) begin
                    check_answer(p, waited, exp_lat[p], exp_r[p]);
                end
            end
            pending = pending & ~seen;
            @(posedge clk);
            // release a port as soon as it answered
            if (seen[0]) begin
                s0_valid <= 1'b0;
            end
            if (seen[1]) begin
                s1_valid <= 1'b0;
            end
            waited++;
        end
        for (int p = 0; p < 2; p++) begin
            assert (!pending[p]) else begin
                errors++;
                $display("port %0d never answered the search for vppn %h", p, q[p]);
            end
            if (use_p[p] && exp_lat[p] != 0 && exp_r[p].found) begin
                tc_idx[p][tc_ptr[p]] = exp_r[p].index;
                tc_v[p][tc_ptr[p]] = 1'b1;
                tc_ptr[p] = (tc_ptr[p] + 1) % `TCACHE_ENTRIES;
            end
        end
        s0_valid <= 1'b0;
        s1_valid <= 1'b0;
    endtask

    // fetch port request withdrawn while the main TLB lookup runs
    task automatic abort_lookup(input row_t r);
        @(posedge clk);
        s0_valid <= 1'b1;
        s0_vppn <= r.vppn;
        s0_va_bit12 <= r.va12;
        s0_asid <= r.asid;
        @(negedge clk);
        assert (!s0_ok) else begin
            errors++;
            $display("CHECK FAILED at %0t: unexpected tcache hit before abort", $time);
        end
        @(posedge clk);
        s0_valid <= 1'b0;
        for (int c = 1; c <= 3; c++) begin
            @(negedge clk);
            assert (!s0_ok) else begin
                errors++;
                $display("CHECK FAILED at %0t: ok raised after the request was dropped", $time);
            end
            // one cycle in PORT_L2_LOOKUP, then idle
            if (c > 1) begin
                assert (u_dut.u_ctrl_inst.state == tlb_ctrl_pkg::PORT_CACHE) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: fetch port did not return to PORT_CACHE",
                             $time);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h1478eec1));
        reset = 1'b1;
        s0_valid = 1'b0;
        s0_vppn = '0;
        s0_va_bit12 = 1'b0;
        s0_asid = '0;
        s1_valid = 1'b0;
        s1_vppn = '0;
        s1_va_bit12 = 1'b0;
        s1_asid = '0;
        invtlb = '0;
        wr = '0;
        r_index = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            shadow[i] = '0;
        end
        flush_model();
        tc_ptr[0] = 0;
        tc_ptr[1] = 0;

        // kind idx vppn vppn_b va12 asid g big op hit
        add(K_WR, 0, 'h00100, 0, 0, 1, 0, 0, 0, 0);
        add(K_WR, 1, 'h00200, 0, 0, 1, 0, 0, 0, 0);
        add(K_WR, 2, 'h00300, 0, 0, 1, 0, 0, 0, 0);
        add(K_WR, 3, 'h04000, 0, 0, 2, 0, 1, 0, 0);
        add(K_WR, 4, 'h08000, 0, 0, 3, 1, 0, 0, 0);
        add(K_WR, 5, 'h0c000, 0, 0, 5, 1, 1, 0, 0);
        add(K_RD, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add(K_RD, 3, 0, 0, 0, 0, 0, 0, 0, 0);
        add(K_RD, 5, 0, 0, 0, 0, 0, 0, 0, 0);
        add(K_S0, 0, 'h00100, 0, 0, 1, 0, 0, 0, 0);
        add(K_S0, 0, 'h00100, 0, 0, 1, 0, 0, 0, 1);
        add(K_S0, 0, 'h00100, 0, 1, 1, 0, 0, 0, 1);
        // third page evicts the first
        add(K_S0, 0, 'h00200, 0, 0, 1, 0, 0, 0, 0);
        add(K_S0, 0, 'h00300, 0, 0, 1, 0, 0, 0, 0);
        add(K_S0, 0, 'h00100, 0, 1, 1, 0, 0, 0, 0);
        add(K_S0, 0, 'h00300, 0, 1, 1, 0, 0, 0, 1);
        // 2M pair, then a foreign asid
        add(K_S1, 0, 'h04005, 0, 0, 2, 0, 0, 0, 0);
        add(K_S1, 0, 'h04105, 0, 0, 2, 0, 0, 0, 2);
        add(K_S1, 0, 'h04005, 0, 0, 7, 0, 0, 0, 0);
        add(K_S1, 0, 'h04005, 0, 0, 7, 0, 0, 0, 0);
        add(K_S1, 0, 'h08000, 0, 1, 9, 0, 0, 0, 0);
        add(K_S1, 0, 'h08000, 0, 1, 9, 0, 0, 0, 2);
        add(K_BOTH, 0, 'h00200, 'h0c0ab, 0, 1, 0, 0, 0, 0);
        add(K_ABORT, 0, 'h04005, 0, 0, 2, 0, 0, 0, 0);
        add(K_S0, 0, 'h04005, 0, 0, 2, 0, 0, 0, 0);
        // invtlb ops with searches after each
        add(K_INV, 0, 'h00100, 0, 0, 1, 0, 0, 5, 0);
        add(K_S0, 0, 'h00100, 0, 0, 1, 0, 0, 0, 0);
        add(K_S0, 0, 'h00200, 0, 0, 1, 0, 0, 0, 0);
        add(K_INV, 0, 0, 0, 0, 2, 0, 0, 4, 0);
        add(K_S1, 0, 'h04005, 0, 0, 2, 0, 0, 0, 0);
        add(K_INV, 0, 'h08000, 0, 0, 9, 0, 0, 6, 0);
        add(K_S1, 0, 'h08000, 0, 0, 9, 0, 0, 0, 0);
        add(K_INV, 0, 0, 0, 0, 0, 0, 0, 3, 0);
        add(K_S0, 0, 'h00300, 0, 0, 1, 0, 0, 0, 0);
        add(K_RD, 2, 0, 0, 0, 0, 0, 0, 0, 0);
        add(K_WR, 1, 'h00200, 0, 0, 1, 0, 0, 0, 0);
        add(K_INV, 0, 0, 0, 0, 0, 0, 0, 2, 0);
        add(K_S1, 0, 'h0c0ab, 0, 0, 4, 0, 0, 0, 0);
        add(K_S0, 0, 'h00200, 0, 0, 1, 0, 0, 0, 0);
        add(K_INV, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add(K_S0, 0, 'h00200, 0, 0, 1, 0, 0, 0, 0);
        add(K_WR, 1, 'h00200, 0, 0, 1, 0, 0, 0, 0);
        add(K_INV, 0, 0, 0, 0, 0, 0, 0, 1, 0);
        add(K_S0, 0, 'h00200, 0, 0, 1, 0, 0, 0, 0);
        limit = rows.size() * 6 + 50;

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        foreach (rows[i]) begin
            case (rows[i].kind)
                K_WR: write_entry(rows[i]);
                K_RD: read_back(rows[i]);
                K_S0: search_ports(rows[i], 2'b01);
                K_S1: search_ports(rows[i], 2'b10);
                K_BOTH: search_ports(rows[i], 2'b11);
                K_INV: invalidate(rows[i]);
                default: abort_lookup(rows[i]);
            endcase
        end

        @(posedge clk);
        errors += u_dut.u_ctrl_inst.u_port_chk.fails + u_dut.u_ctrl_data.u_port_chk.fails;
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tlb_subsys.f
+incdir+include
hdl/tlb_types_pkg.sv
hdl/tlb_ctrl_pkg.sv
hdl/tlb_main.sv
hdl/tcache.sv
hdl/tlb_port_ctrl.sv
hdl/tlb_top.sv
testbench/tlb_top_chk.sv
testbench/tlb_top_tb.sv
